// File: verilog.f
verilog/usb_pkg.sv
verilog/usb_endpoint_control.sv
verilog/usb_response_fsm.sv
verilog/usb_bus_timers.sv
verilog/usb_protocol_top.sv
tests/usb_protocol_assertions.sv
tests/tb_usb_protocol.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the testbench with Verilator, result taken from sim.log
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal -f verilog.f \
  --top-module tb_usb_protocol --Mdir obj_dir -o sim_tb > build.log 2>&1 \
  || { echo "Build failed, see build.log"; exit 1; }
./obj_dir/sim_tb > sim.log 2>&1 || echo "Simulator returned an error status"
cat sim.log
grep -q "TESTBENCH FAILED" sim.log && { echo "Run failed"; exit 1; }
grep -q "TESTBENCH PASSED" sim.log || { echo "Run ended without a result"; exit 1; }
echo "Run passed" && exit 0

// File: tests/tb_usb_protocol.sv
`timescale 1ns/10ps

module tb_usb_protocol;

  typedef enum {ROW_TXN, ROW_RECONF, ROW_TIMEOUT} row_kind_e;
  typedef enum {EXP_NONE, EXP_HSK, EXP_DATA} exp_kind_e;

  typedef struct {
    row_kind_e          kind;
    usb_pkg::usb_pid_t  pid;
    usb_pkg::usb_addr_t addr;
    usb_pkg::usb_endp_t endp;
    logic [15:0]        status;
    usb_pkg::usb_pid_t  data_pid;
    exp_kind_e          exp_kind;
    usb_pkg::usb_pid_t  exp_pid;
    logic [3:0]         exp_fin;
  } row_t;

  logic clock;
  logic reset;
  logic set_conf_i;
  logic clr_conf_i;
  logic tok_recv_i;
  logic usb_recv_i;
  logic crc_error_i;
  logic eop_recv_i;
  logic hsk_recv_i;
  logic rx_sop_i;
  logic hsk_sent_i;
  logic usb_busy_i;
  logic usb_sent_i;
  logic ep0_parity_i;
  logic hsk_send_o;
  logic mux_enable_o;
  logic timeout_o;
  logic [3:0] ep_select_o;
  logic [3:0] ep_finish_o;
  usb_pkg::usb_addr_t usb_addr_i;
  usb_pkg::token_t token_i;
  usb_pkg::usb_pid_t data_pid_i;
  usb_pkg::usb_pid_t pid_o;
  usb_pkg::mux_sel_t mux_select_o;
  usb_pkg::ep_status_t [usb_pkg::NUM_BULK_EP-1:0] ep_status_i;

  row_t rows[$];
  int   errors = 0;
  int   checks = 0;
  int   cycles = 0;
  int   cycle_limit = 100000;
  int   seed = 32'h6693;

  usb_protocol_top uut (.*);

  initial begin
    clock = 1'b0;
    forever #50 clock = ~clock;
  end

  // Watchdog on the whole run
  always @(posedge clock) begin
    cycles++;
    if (cycles > cycle_limit) begin
      $display("Timeout: run exceeded %0d cycles", cycle_limit);
      $display("TESTBENCH FAILED");
      $finish;
    end
  end

  task automatic step_cycle();
    @(posedge clock);
    #10;
  endtask

  task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
    checks++;
    assert (got === exp) else begin
      errors++;
      $display("Mismatch at %0t: %s got %0h expected %0h", $time, name, got, exp);
    end
  endtask

  function automatic row_t make_row(row_kind_e kind, usb_pkg::usb_pid_t pid,
                                    usb_pkg::usb_addr_t addr, usb_pkg::usb_endp_t endp,
                                    logic [15:0] status, usb_pkg::usb_pid_t data_pid,
                                    exp_kind_e exp_kind, usb_pkg::usb_pid_t exp_pid,
                                    logic [3:0] exp_fin);
    row_t r;
    r.kind     = kind;
    r.pid      = pid;
    r.addr     = addr;
    r.endp     = endp;
    r.status   = status;
    r.data_pid = data_pid;
    r.exp_kind = exp_kind;
    r.exp_pid  = exp_pid;
    r.exp_fin  = exp_fin;
    return r;
  endfunction

  // Encoder source expected for an endpoint number
  function automatic usb_pkg::mux_sel_t mux_for_endp(usb_pkg::usb_endp_t endp);
    usb_pkg::mux_sel_t sel;
    sel = (endp == 0) ? usb_pkg::mux_sel_t'(0) : usb_pkg::MUX_SEL_NONE;
    for (int i = 0; i < usb_pkg::NUM_BULK_EP; i++) begin
      if (usb_pkg::BULK_EP_NUM[i] == endp) sel = usb_pkg::mux_sel_t'(i + 1);
    end
    return sel;
  endfunction

  task automatic quiet_window();
    for (int i = 0; i < 4; i++) begin
      check_value("hsk_send_o", hsk_send_o, 1'b0);
      check_value("mux_enable_o", mux_enable_o, 1'b0);
      check_value("ep_finish_o", ep_finish_o, 4'b0);
      step_cycle();
    end
  endtask

  task automatic wait_handshake(input usb_pkg::usb_pid_t exp_pid, input logic [3:0] exp_fin);
    int n;
    n = 0;
    while (!hsk_send_o && n < 20) begin
      step_cycle();
      n++;
    end
    checks++;
    assert (hsk_send_o) else begin
      errors++;
      $display("No handshake request seen by %0t", $time);
    end
    check_value("pid_o", pid_o, exp_pid);
    // Encoder holds off one cycle before taking the handshake
    step_cycle();
    check_value("hsk_send_o", hsk_send_o, 1'b1);
    check_value("pid_o", pid_o, exp_pid);
    hsk_sent_i = 1'b1;
    step_cycle();
    hsk_sent_i = 1'b0;
    check_value("hsk_send_o", hsk_send_o, 1'b0);
    check_value("ep_finish_o", ep_finish_o, exp_fin);
    step_cycle();
    check_value("ep_finish_o", ep_finish_o, 4'b0);
    check_value("ep_select_o", ep_select_o, 4'b0);
  endtask

  task automatic run_token(input row_t r);
    int n;
    tok_recv_i = 1'b1;
    token_i.addr = r.addr;
    token_i.endp = r.endp;
    token_i.pid = r.pid;
    step_cycle();
    tok_recv_i = 1'b0;
    if (r.exp_fin != 4'b0) begin
      check_value("ep_select_o", ep_select_o, r.exp_fin);
    end
    if (r.kind == ROW_TIMEOUT) begin
      n = 1;
      while (!timeout_o && n < 60) begin
        check_value("hsk_send_o", hsk_send_o, 1'b0);
        step_cycle();
        n++;
      end
      check_value("timeout cycles", n, usb_pkg::TD_TIMEOUT_CYCLES + 1);
      step_cycle();
      check_value("state", uut.state, usb_pkg::ST_IDLE);
      check_value("hsk_send_o", hsk_send_o, 1'b0);
    end else if (r.exp_kind == EXP_DATA) begin
      check_value("mux_enable_o", mux_enable_o, 1'b1);
      check_value("mux_select_o", mux_select_o, mux_for_endp(r.endp));
      check_value("pid_o", pid_o, r.exp_pid);
      usb_busy_i = 1'b1;
      step_cycle();
      usb_busy_i = 1'b0;
      usb_sent_i = 1'b1;
      step_cycle();
      usb_sent_i = 1'b0;
      hsk_recv_i = 1'b1;
      step_cycle();
      hsk_recv_i = 1'b0;
      check_value("ep_finish_o", ep_finish_o, r.exp_fin);
      check_value("mux_enable_o", mux_enable_o, 1'b0);
    end else if (r.pid == usb_pkg::PID_OUT || r.pid == usb_pkg::PID_SETUP) begin
      rx_sop_i = 1'b1;
      step_cycle();
      rx_sop_i = 1'b0;
      usb_recv_i = 1'b1;
      eop_recv_i = 1'b1;
      data_pid_i = r.data_pid;
      step_cycle();
      usb_recv_i = 1'b0;
      eop_recv_i = 1'b0;
      if (r.exp_kind == EXP_HSK) begin
        // Handshake follows the data packet by one cycle
        check_value("hsk_send_o", hsk_send_o, 1'b1);
        wait_handshake(r.exp_pid, r.exp_fin);
      end else begin
        quiet_window();
      end
    end else if (r.exp_kind == EXP_HSK) begin
      // PING and refused IN answer on the first cycle
      check_value("hsk_send_o", hsk_send_o, 1'b1);
      wait_handshake(r.exp_pid, r.exp_fin);
    end else begin
      quiet_window();
    end
  endtask

  task automatic run_row(input row_t r);
    ep_status_i = r.status;
    step_cycle();
    if (r.kind == ROW_RECONF) begin
      clr_conf_i = 1'b1;
      step_cycle();
      clr_conf_i = 1'b0;
      set_conf_i = 1'b1;
      step_cycle();
      set_conf_i = 1'b0;
      step_cycle();
    end else begin
      run_token(r);
    end
  endtask

  task automatic build_table();
    logic       rdy;
    logic [15:0] st;
    usb_pkg::usb_pid_t hsk;
    rows.push_back(make_row(ROW_TXN, usb_pkg::PID_PING, 7'h05, 4'd1, 16'hCCCC, 4'h0,
                            EXP_HSK, usb_pkg::PID_ACK, 4'b0000));
    rows.push_back(make_row(ROW_TXN, usb_pkg::PID_PING, 7'h05, 4'd1, 16'hCCC4, 4'h0,
                            EXP_HSK, usb_pkg::PID_NAK, 4'b0000));
    rows.push_back(make_row(ROW_TXN, usb_pkg::PID_PING, 7'h05, 4'd2, 16'hCCCC, 4'h0,
                            EXP_HSK, usb_pkg::PID_STALL, 4'b0000));
    rows.push_back(make_row(ROW_TXN, usb_pkg::PID_PING, 7'h05, 4'd5, 16'hCCCC, 4'h0,
                            EXP_HSK, usb_pkg::PID_STALL, 4'b0000));
    rows.push_back(make_row(ROW_TXN, usb_pkg::PID_OUT, 7'h05, 4'd1, 16'hCCCC,
                            usb_pkg::PID_DATA0, EXP_HSK, usb_pkg::PID_ACK, 4'b0001));
    rows.push_back(make_row(ROW_TXN, usb_pkg::PID_OUT, 7'h05, 4'd1, 16'hCCCE,
                            usb_pkg::PID_DATA1, EXP_HSK, usb_pkg::PID_ACK, 4'b0001));
    rows.push_back(make_row(ROW_TXN, usb_pkg::PID_OUT, 7'h05, 4'd1, 16'hCCCC,
                            usb_pkg::PID_DATA1, EXP_NONE, 4'h0, 4'b0000));
    rows.push_back(make_row(ROW_TXN, usb_pkg::PID_OUT, 7'h05, 4'd3, 16'hCCCC,
                            usb_pkg::PID_DATA0, EXP_HSK, usb_pkg::PID_ACK, 4'b0100));
    rows.push_back(make_row(ROW_TXN, usb_pkg::PID_IN, 7'h05, 4'd2, 16'hCCCC, 4'h0,
                            EXP_DATA, usb_pkg::PID_DATA0, 4'b0010));
    rows.push_back(make_row(ROW_TXN, usb_pkg::PID_IN, 7'h05, 4'd4, 16'hCCCC, 4'h0,
                            EXP_DATA, usb_pkg::PID_DATA0, 4'b1000));
    rows.push_back(make_row(ROW_TXN, usb_pkg::PID_IN, 7'h05, 4'd2, 16'hCCEC, 4'h0,
                            EXP_DATA, usb_pkg::PID_DATA1, 4'b0010));
    rows.push_back(make_row(ROW_TXN, usb_pkg::PID_IN, 7'h05, 4'd2, 16'hCC8C, 4'h0,
                            EXP_HSK, usb_pkg::PID_NAK, 4'b0000));
    rows.push_back(make_row(ROW_TXN, usb_pkg::PID_PING, 7'h06, 4'd1, 16'hCCCC, 4'h0,
                            EXP_NONE, 4'h0, 4'b0000));
    rows.push_back(make_row(ROW_TXN, usb_pkg::PID_SETUP, 7'h05, 4'd0, 16'hCCCC,
                            usb_pkg::PID_DATA0, EXP_HSK, usb_pkg::PID_ACK, 4'b0000));
    rows.push_back(make_row(ROW_TXN, usb_pkg::PID_SETUP, 7'h05, 4'd1, 16'hCCCC,
                            usb_pkg::PID_DATA0, EXP_HSK, usb_pkg::PID_STALL, 4'b0000));
    // Halt on EP1 sticks until the device is configured again
    rows.push_back(make_row(ROW_TXN, usb_pkg::PID_PING, 7'h05, 4'd1, 16'hCCCD, 4'h0,
                            EXP_HSK, usb_pkg::PID_STALL, 4'b0000));
    rows.push_back(make_row(ROW_TXN, usb_pkg::PID_PING, 7'h05, 4'd1, 16'hCCCC, 4'h0,
                            EXP_HSK, usb_pkg::PID_STALL, 4'b0000));
    rows.push_back(make_row(ROW_RECONF, 4'h0, 7'h05, 4'd0, 16'hCCCC, 4'h0,
                            EXP_NONE, 4'h0, 4'b0000));
    rows.push_back(make_row(ROW_TXN, usb_pkg::PID_PING, 7'h05, 4'd1, 16'hCCCC, 4'h0,
                            EXP_HSK, usb_pkg::PID_ACK, 4'b0000));
    rows.push_back(make_row(ROW_TIMEOUT, usb_pkg::PID_OUT, 7'h05, 4'd1, 16'hCCCC, 4'h0,
                            EXP_NONE, 4'h0, 4'b0000));
    // PING with random receive readiness on every bulk endpoint
    for (int i = 0; i < usb_pkg::NUM_BULK_EP; i++) begin
      rdy = 1'($random(seed));
      st = 16'hCCCC;
      st[i*4+3] = rdy;
      if (!usb_pkg::BULK_EP_OUT[i]) hsk = usb_pkg::PID_STALL;
      else hsk = rdy ? usb_pkg::PID_ACK : usb_pkg::PID_NAK;
      rows.push_back(make_row(ROW_TXN, usb_pkg::PID_PING, 7'h05, usb_pkg::BULK_EP_NUM[i], st,
                              4'h0, EXP_HSK, hsk, 4'b0000));
    end
  endtask

  initial begin
    reset = 1'b1;
    set_conf_i = 1'b0;
    clr_conf_i = 1'b0;
    tok_recv_i = 1'b0;
    usb_recv_i = 1'b0;
    crc_error_i = 1'b0;
    eop_recv_i = 1'b0;
    hsk_recv_i = 1'b0;
    rx_sop_i = 1'b0;
    hsk_sent_i = 1'b0;
    usb_busy_i = 1'b0;
    usb_sent_i = 1'b0;
    ep0_parity_i = 1'b0;
    usb_addr_i = 7'h05;
    token_i = '0;
    data_pid_i = usb_pkg::PID_DATA0;
    ep_status_i = 16'hCCCC;
    build_table();
    cycle_limit = 200 * rows.size() + 20;
    repeat (3) @(posedge clock);
    #10;
    reset = 1'b0;
    check_value("hsk_send_o", hsk_send_o, 1'b0);
    check_value("mux_enable_o", mux_enable_o, 1'b0);
    check_value("mux_select_o", mux_select_o, usb_pkg::MUX_SEL_NONE);
    check_value("ep_select_o", ep_select_o, 4'b0);
    check_value("ep_finish_o", ep_finish_o, 4'b0);
    check_value("timeout_o", timeout_o, 1'b0);
    set_conf_i = 1'b1;
    step_cycle();
    set_conf_i = 1'b0;
    foreach (rows[i]) begin
      run_row(rows[i]);
    end
    step_cycle();
    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

endmodule

// File: tests/usb_protocol_assertions.sv
`timescale 1ns/10ps

module usb_protocol_assertions (
  input logic              clock,
  input logic              reset,
  input logic              hsk_send_i,
  input logic              mux_enable_i,
  input usb_pkg::usb_pid_t pid_i
);

  // Handshake and data phases exclude each other
  hsk_data_exclusive: assert property (@(posedge clock) disable iff (reset)
    !(hsk_send_i && mux_enable_i))
    else $error("hsk_send_o and mux_enable_o are high together");

  // PID holds while the encoder stalls
  hsk_pid_stable: assert property (@(posedge clock) disable iff (reset)
    (hsk_send_i && $past(hsk_send_i)) |-> (pid_i == $past(pid_i)))
    else $error("pid_o changed while hsk_send_o was high");

endmodule

bind usb_response_fsm usb_protocol_assertions u_protocol_assertions (
  .clock        (clock),
  .reset        (reset),
  .hsk_send_i   (hsk_send_o),
  .mux_enable_i (mux_enable_o),
  .pid_i        (pid_o)
);

// File: verilog/usb_protocol_top.sv
`timescale 1ns/10ps

module usb_protocol_top (
  input  logic                                            clock,
  input  logic                                            reset,
  input  logic                                            set_conf_i,
  input  logic                                            clr_conf_i,
  input  usb_pkg::usb_addr_t                              usb_addr_i,
  // Packet decoder
  input  logic                                            tok_recv_i,
  input  usb_pkg::token_t                                 token_i,
  input  logic                                            usb_recv_i,
  input  usb_pkg::usb_pid_t                               data_pid_i,
  input  logic                                            crc_error_i,
  input  logic                                            eop_recv_i,
  input  logic                                            hsk_recv_i,
  input  logic                                            rx_sop_i,
  // Packet encoder
  input  logic                                            hsk_sent_i,
  input  logic                                            usb_busy_i,
  input  logic                                            usb_sent_i,
  output logic                                            hsk_send_o,
  output usb_pkg::usb_pid_t                               pid_o,
  output logic                                            mux_enable_o,
  output usb_pkg::mux_sel_t                               mux_select_o,
  // Endpoints
  input  usb_pkg::ep_status_t [usb_pkg::NUM_BULK_EP-1:0] ep_status_i,
  input  logic                                            ep0_parity_i,
  output logic [usb_pkg::NUM_BULK_EP-1:0]                 ep_select_o,
  output logic [usb_pkg::NUM_BULK_EP-1:0]                 ep_finish_o,
  output logic                                            timeout_o
);

  usb_pkg::ep_summary_t summary;
  usb_pkg::resp_state_t state;
  logic                 tok_match;

  usb_endpoint_control u_ep_ctrl (
    .clock       (clock),
    .reset       (reset),
    .set_conf_i  (set_conf_i),
    .clr_conf_i  (clr_conf_i),
    .tok_recv_i  (tok_recv_i),
    .token_i     (token_i),
    .usb_addr_i  (usb_addr_i),
    .ep_status_i (ep_status_i),
    .hsk_recv_i  (hsk_recv_i),
    .hsk_sent_i  (hsk_sent_i),
    .timeout_i   (timeout_o),
    .summary_o   (summary),
    .ep_select_o (ep_select_o),
    .ep_finish_o (ep_finish_o)
  );

  usb_response_fsm u_fsm (
    .clock        (clock),
    .reset        (reset),
    .tok_recv_i   (tok_recv_i),
    .token_i      (token_i),
    .usb_addr_i   (usb_addr_i),
    .summary_i    (summary),
    .ep0_parity_i (ep0_parity_i),
    .usb_recv_i   (usb_recv_i),
    .data_pid_i   (data_pid_i),
    .crc_error_i  (crc_error_i),
    .eop_recv_i   (eop_recv_i),
    .hsk_recv_i   (hsk_recv_i),
    .hsk_sent_i   (hsk_sent_i),
    .usb_sent_i   (usb_sent_i),
    .timeout_i    (timeout_o),
    .state_o      (state),
    .tok_match_o  (tok_match),
    .hsk_send_o   (hsk_send_o),
    .pid_o        (pid_o),
    .mux_enable_o (mux_enable_o),
    .mux_select_o (mux_select_o)
  );

  usb_bus_timers u_timers (
    .clock       (clock),
    .reset       (reset),
    .state_i     (state),
    .tok_match_i (tok_match),
    .token_pid_i (token_i.pid),
    .rx_sop_i    (rx_sop_i),
    .usb_busy_i  (usb_busy_i),
    .usb_sent_i  (usb_sent_i),
    .hsk_recv_i  (hsk_recv_i),
    .timeout_o   (timeout_o)
  );

endmodule

// File: verilog/usb_bus_timers.sv
`timescale 1ns/10ps

module usb_bus_timers (
  input  logic                 clock,
  input  logic                 reset,
  input  usb_pkg::resp_state_t state_i,
  input  logic                 tok_match_i,
  input  usb_pkg::usb_pid_t    token_pid_i,
  input  logic                 rx_sop_i,
  input  logic                 usb_busy_i,
  input  logic                 usb_sent_i,
  input  logic                 hsk_recv_i,
  output logic                 timeout_o
);

  // Timer 0 is token to data, 1 endpoint to data, 2 turnaround
  logic [2:0]          start;
  logic [2:0]          stop;
  logic [2:0]          expire;
  usb_pkg::timer_cnt_t load [3];
  logic                tok_start;
  logic                timeout_q;

  assign tok_start = (state_i == usb_pkg::ST_IDLE) && tok_match_i;

  assign start[0] = tok_start &&
                    ((token_pid_i == usb_pkg::PID_OUT) || (token_pid_i == usb_pkg::PID_SETUP));
  assign start[1] = tok_start && (token_pid_i == usb_pkg::PID_IN);
  assign start[2] = (state_i == usb_pkg::ST_SEND) && usb_sent_i;

  // Each timer waits for its own event
  assign stop = {hsk_recv_i, usb_busy_i, rx_sop_i};

  assign load[0] = usb_pkg::timer_cnt_t'(usb_pkg::TD_TIMEOUT_CYCLES - 1);
  assign load[1] = usb_pkg::timer_cnt_t'(usb_pkg::EP_TIMEOUT_CYCLES - 1);
  assign load[2] = usb_pkg::timer_cnt_t'(usb_pkg::TA_TIMEOUT_CYCLES - 1);

  for (genvar i = 0; i < 3; i++) begin : g_timer
    usb_pkg::timer_cnt_t count_q;
    logic                run_q;

    // Event in the last cycle still counts as in time
    assign expire[i] = run_q && (count_q == '0) && !stop[i];

    always_ff @(posedge clock) begin
      if (reset) begin
        run_q <= 1'b0;
      end else if (start[i]) begin
        run_q <= 1'b1;
      end else if (stop[i] || expire[i]) begin
        run_q <= 1'b0;
      end
    end

    always_ff @(posedge clock) begin
      if (start[i]) begin
        count_q <= load[i];
      end else if (run_q && count_q != '0) begin
        count_q <= count_q - 1'b1;
      end
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      timeout_q <= 1'b0;
    end else begin
      timeout_q <= |expire;
    end
  end

  assign timeout_o = timeout_q;

endmodule

// File: verilog/usb_response_fsm.sv
`timescale 1ns/10ps

module usb_response_fsm (
  input  logic                 clock,
  input  logic                 reset,
  input  logic                 tok_recv_i,
  input  usb_pkg::token_t      token_i,
  input  usb_pkg::usb_addr_t   usb_addr_i,
  input  usb_pkg::ep_summary_t summary_i,
  input  logic                 ep0_parity_i,
  input  logic                 usb_recv_i,
  input  usb_pkg::usb_pid_t    data_pid_i,
  input  logic                 crc_error_i,
  input  logic                 eop_recv_i,
  input  logic                 hsk_recv_i,
  input  logic                 hsk_sent_i,
  input  logic                 usb_sent_i,
  input  logic                 timeout_i,
  output usb_pkg::resp_state_t state_o,
  output logic                 tok_match_o,
  output logic                 hsk_send_o,
  output usb_pkg::usb_pid_t    pid_o,
  output logic                 mux_enable_o,
  output usb_pkg::mux_sel_t    mux_select_o
);

  usb_pkg::resp_state_t state_q;
  usb_pkg::resp_state_t state_d;
  usb_pkg::usb_pid_t    pid_q;
  usb_pkg::usb_pid_t    pid_d;
  usb_pkg::usb_pid_t    tx_data_pid;
  usb_pkg::mux_sel_t    mux_sel_q;
  logic                 tok_match;
  logic                 seq_d;
  logic                 seq_q;
  logic                 data_ok;

  assign tok_match = tok_recv_i && (token_i.addr == usb_addr_i);

  // Expected DATAx bit of the targeted endpoint
  assign seq_d       = summary_i.ep0_hit ? ep0_parity_i : summary_i.seq_bit;
  assign tx_data_pid = seq_d ? usb_pkg::PID_DATA1 : usb_pkg::PID_DATA0;

  assign data_ok = ((data_pid_i == usb_pkg::PID_DATA0) || (data_pid_i == usb_pkg::PID_DATA1)) &&
                   (data_pid_i[3] == seq_q);

  always_comb begin
    state_d = state_q;
    pid_d   = pid_q;
    case (state_q)
      usb_pkg::ST_IDLE: begin
        if (tok_match) begin
          case (token_i.pid)
            usb_pkg::PID_SETUP: begin
              if (summary_i.ep0_hit) begin
                state_d = usb_pkg::ST_RECV;
              end else begin
                state_d = usb_pkg::ST_DROP;
                pid_d   = usb_pkg::PID_STALL;
              end
            end
            usb_pkg::PID_OUT: begin
              if (summary_i.ep0_hit || summary_i.out_rdy) begin
                state_d = usb_pkg::ST_RECV;
              end else begin
                // Let the data packet pass, then refuse it
                state_d = usb_pkg::ST_DROP;
                pid_d   = summary_i.out_sel ? usb_pkg::PID_NAK : usb_pkg::PID_STALL;
              end
            end
            usb_pkg::PID_IN: begin
              if (summary_i.ep0_hit || summary_i.in_rdy) begin
                state_d = usb_pkg::ST_SEND;
                pid_d   = tx_data_pid;
              end else begin
                state_d = usb_pkg::ST_RESP;
                pid_d   = summary_i.in_sel ? usb_pkg::PID_NAK : usb_pkg::PID_STALL;
              end
            end
            usb_pkg::PID_PING: begin
              state_d = usb_pkg::ST_RESP;
              if (summary_i.ep0_hit || summary_i.out_rdy) begin
                pid_d = usb_pkg::PID_ACK;
              end else begin
                pid_d = summary_i.out_sel ? usb_pkg::PID_NAK : usb_pkg::PID_STALL;
              end
            end
            default: begin
              state_d = usb_pkg::ST_IDLE;
            end
          endcase
        end
      end
      usb_pkg::ST_RECV: begin
        if (usb_recv_i) begin
          // Sequence error drops the packet silently
          state_d = data_ok ? usb_pkg::ST_RESP : usb_pkg::ST_IDLE;
          pid_d   = usb_pkg::PID_ACK;
        end else if (crc_error_i || timeout_i) begin
          state_d = usb_pkg::ST_IDLE;
        end
      end
      usb_pkg::ST_DROP: begin
        if (crc_error_i || timeout_i) begin
          state_d = usb_pkg::ST_IDLE;
        end else if (eop_recv_i) begin
          state_d = usb_pkg::ST_RESP;
        end
      end
      usb_pkg::ST_RESP: begin
        if (hsk_sent_i) begin
          state_d = usb_pkg::ST_IDLE;
        end
      end
      usb_pkg::ST_SEND: begin
        if (usb_sent_i) begin
          state_d = usb_pkg::ST_WAIT;
        end else if (timeout_i) begin
          state_d = usb_pkg::ST_IDLE;
        end
      end
      usb_pkg::ST_WAIT: begin
        // Host ACK, or turnaround expiry
        if (hsk_recv_i || timeout_i) begin
          state_d = usb_pkg::ST_IDLE;
        end
      end
      default: begin
        state_d = usb_pkg::ST_IDLE;
      end
    endcase
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      state_q   <= usb_pkg::ST_IDLE;
      mux_sel_q <= usb_pkg::MUX_SEL_NONE;
    end else begin
      state_q <= state_d;
      if (state_d == usb_pkg::ST_IDLE) begin
        mux_sel_q <= usb_pkg::MUX_SEL_NONE;
      end else if (state_q == usb_pkg::ST_IDLE && state_d == usb_pkg::ST_SEND) begin
        mux_sel_q <= summary_i.mux_sel;
      end
    end
  end

  always_ff @(posedge clock) begin
    pid_q <= pid_d;
    if (state_q == usb_pkg::ST_IDLE && tok_match) begin
      seq_q <= seq_d;
    end
  end

  assign state_o      = state_q;
  assign tok_match_o  = tok_match;
  assign hsk_send_o   = state_q == usb_pkg::ST_RESP;
  assign pid_o        = pid_q;
  assign mux_enable_o = (state_q == usb_pkg::ST_SEND) || (state_q == usb_pkg::ST_WAIT);
  assign mux_select_o = mux_sel_q;

endmodule

// File: verilog/usb_endpoint_control.sv
`timescale 1ns/10ps

module usb_endpoint_control (
  input  logic                                            clock,
  input  logic                                            reset,
  input  logic                                            set_conf_i,
  input  logic                                            clr_conf_i,
  input  logic                                            tok_recv_i,
  input  usb_pkg::token_t                                 token_i,
  input  usb_pkg::usb_addr_t                              usb_addr_i,
  input  usb_pkg::ep_status_t [usb_pkg::NUM_BULK_EP-1:0] ep_status_i,
  input  logic                                            hsk_recv_i,
  input  logic                                            hsk_sent_i,
  input  logic                                            timeout_i,
  output usb_pkg::ep_summary_t                            summary_o,
  output logic [usb_pkg::NUM_BULK_EP-1:0]                 ep_select_o,
  output logic [usb_pkg::NUM_BULK_EP-1:0]                 ep_finish_o
);

  logic [usb_pkg::NUM_BULK_EP-1:0] en_q;
  logic [usb_pkg::NUM_BULK_EP-1:0] hit;
  logic [usb_pkg::NUM_BULK_EP-1:0] out_sel;
  logic [usb_pkg::NUM_BULK_EP-1:0] out_rdy;
  logic [usb_pkg::NUM_BULK_EP-1:0] in_sel;
  logic [usb_pkg::NUM_BULK_EP-1:0] in_rdy;
  logic [usb_pkg::NUM_BULK_EP-1:0] parity;
  logic [usb_pkg::NUM_BULK_EP-1:0] sel_d;
  logic [usb_pkg::NUM_BULK_EP-1:0] sel_q;
  logic [usb_pkg::NUM_BULK_EP-1:0] finish_q;
  logic                            end_q;
  logic                            tok_match;
  logic                            ep0_hit;
  usb_pkg::mux_sel_t               mux_sel;

  assign tok_match = tok_recv_i && (token_i.addr == usb_addr_i);
  assign ep0_hit   = token_i.endp == '0;

  for (genvar i = 0; i < usb_pkg::NUM_BULK_EP; i++) begin : g_ep
    // Endpoint is enabled by configuration and dropped on halt
    always_ff @(posedge clock) begin
      if (reset || clr_conf_i || ep_status_i[i].halted) begin
        en_q[i] <= 1'b0;
      end else if (set_conf_i) begin
        en_q[i] <= (usb_pkg::BULK_EP_NUM[i] != '0) &&
                   (usb_pkg::BULK_EP_OUT[i] || usb_pkg::BULK_EP_IN[i]);
      end
    end

    assign hit[i]     = token_i.endp == usb_pkg::BULK_EP_NUM[i];
    assign out_sel[i] = en_q[i] && usb_pkg::BULK_EP_OUT[i] && hit[i];
    assign out_rdy[i] = out_sel[i] && ep_status_i[i].rx_rdy && !ep_status_i[i].halted;
    assign in_sel[i]  = en_q[i] && usb_pkg::BULK_EP_IN[i] && hit[i];
    assign in_rdy[i]  = in_sel[i] && ep_status_i[i].tx_rdy && !ep_status_i[i].halted;
    assign parity[i]  = ep_status_i[i].parity;

    // Only an OUT or IN token that will move data selects the endpoint
    assign sel_d[i] = ((token_i.pid == usb_pkg::PID_OUT) && out_rdy[i]) ||
                      ((token_i.pid == usb_pkg::PID_IN) && in_rdy[i]);
  end

  // Encoder source follows the token's endpoint number
  always_comb begin
    mux_sel = usb_pkg::MUX_SEL_NONE;
    if (ep0_hit) begin
      mux_sel = '0;
    end
    for (int i = 0; i < usb_pkg::NUM_BULK_EP; i++) begin
      if (hit[i]) begin
        mux_sel = usb_pkg::mux_sel_t'(i + 1);
      end
    end
  end

  always_comb begin
    summary_o.ep0_hit = ep0_hit;
    summary_o.out_sel = |out_sel;
    summary_o.out_rdy = |out_rdy;
    summary_o.in_sel  = |in_sel;
    summary_o.in_rdy  = |in_rdy;
    summary_o.seq_bit = |(hit & parity);
    summary_o.mux_sel = mux_sel;
  end

  // Any of these ends the transaction
  always_ff @(posedge clock) begin
    if (reset) begin
      end_q <= 1'b0;
    end else begin
      end_q <= clr_conf_i || hsk_recv_i || hsk_sent_i || timeout_i;
    end
  end

  // A new token takes over the selects
  always_ff @(posedge clock) begin
    if (reset) begin
      sel_q <= '0;
    end else if (tok_match) begin
      sel_q <= sel_d;
    end else if (end_q) begin
      sel_q <= '0;
    end
  end

  // OUT endpoints finish on our handshake, IN endpoints on the host's
  always_ff @(posedge clock) begin
    if (reset || end_q) begin
      finish_q <= '0;
    end else begin
      finish_q <= sel_q & ((usb_pkg::BULK_EP_OUT & {usb_pkg::NUM_BULK_EP{hsk_sent_i}}) |
                           (usb_pkg::BULK_EP_IN & {usb_pkg::NUM_BULK_EP{hsk_recv_i}}));
    end
  end

  assign ep_select_o = sel_q;
  assign ep_finish_o = finish_q;

endmodule

// File: verilog/usb_pkg.sv
package usb_pkg;

  // Basic field widths of the USB 2.0 token and data packets
  typedef logic [3:0] usb_pid_t;
  typedef logic [6:0] usb_addr_t;
  typedef logic [3:0] usb_endp_t;

  // Token PIDs
  localparam usb_pid_t PID_OUT   = 4'b0001;
  localparam usb_pid_t PID_IN    = 4'b1001;
  localparam usb_pid_t PID_SETUP = 4'b1101;
  localparam usb_pid_t PID_PING  = 4'b0100;

  // Data PIDs, bit 3 is the sequence bit
  localparam usb_pid_t PID_DATA0 = 4'b0011;
  localparam usb_pid_t PID_DATA1 = 4'b1011;

  // Handshake PIDs
  localparam usb_pid_t PID_ACK   = 4'b0010;
  localparam usb_pid_t PID_NAK   = 4'b1010;
  localparam usb_pid_t PID_STALL = 4'b1110;

  // Bulk endpoint map, index 0 is the first bulk endpoint
  localparam int NUM_BULK_EP = 4;
  localparam usb_endp_t [NUM_BULK_EP-1:0] BULK_EP_NUM = {4'd4, 4'd3, 4'd2, 4'd1};
  localparam logic [NUM_BULK_EP-1:0] BULK_EP_OUT = 4'b0101;
  localparam logic [NUM_BULK_EP-1:0] BULK_EP_IN  = 4'b1010;

  // Encoder data source select, 0 is EP0 and 1 to 4 the bulk endpoints
  typedef logic [2:0] mux_sel_t;
  localparam mux_sel_t MUX_SEL_NONE = 3'd7;

  // Bus timer limits in clock cycles
  localparam int TD_TIMEOUT_CYCLES = 24;
  localparam int EP_TIMEOUT_CYCLES = 24;
  localparam int TA_TIMEOUT_CYCLES = 102;

  // Sized for the longest limit
  typedef logic [$clog2(TA_TIMEOUT_CYCLES)-1:0] timer_cnt_t;

  typedef struct packed {
    usb_addr_t addr;
    usb_endp_t endp;
    usb_pid_t  pid;
  } token_t;

  typedef struct packed {
    logic rx_rdy;
    logic tx_rdy;
    logic parity;
    logic halted;
  } ep_status_t;

  typedef struct packed {
    logic     ep0_hit;
    logic     out_sel;
    logic     out_rdy;
    logic     in_sel;
    logic     in_rdy;
    logic     seq_bit;
    mux_sel_t mux_sel;
  } ep_summary_t;

  typedef enum logic [2:0] {
    ST_IDLE,
    ST_RECV,
    ST_RESP,
    ST_DROP,
    ST_SEND,
    ST_WAIT
  } resp_state_t;

endpackage
